/* rtl/operandFetch.sv */
`timescale 1ns/1ps

module operandFetch (
  input  logic clk,
  input  logic rstN,
  input  regReadPkg::issueUopT issue,
  output regReadPkg::rfReadReqT [regReadPkg::NUM_OPERANDS-1:0] readReq,
  input  logic [regReadPkg::NUM_OPERANDS-1:0][regReadPkg::DATA_W-1:0] readData,
  output regReadPkg::exUopT exUop
);

  localparam int PAD_W = regReadPkg::DATA_W - regReadPkg::REG_IDX_W;

  regReadPkg::regTagT [regReadPkg::NUM_OPERANDS-1:0] tag;
  logic validQ;
  logic [regReadPkg::ID_W-1:0] idQ;
  logic [regReadPkg::NUM_OPERANDS-1:0] useConstQ;
  logic [regReadPkg::NUM_OPERANDS-1:0][regReadPkg::REG_IDX_W-1:0] constQ;
  logic [regReadPkg::NUM_OPERANDS-1:0][regReadPkg::DATA_W-1:0] operand;

  assign tag[0] = issue.tagA;
  assign tag[1] = issue.tagB;

  // ************************************************************
  // Read requests
  // ************************************************************
  always_comb begin
    for (int k = 0; k < regReadPkg::NUM_OPERANDS; k++) begin
      readReq[k].valid = issue.valid && !tag[k].regRef.noReg;
      readReq[k].idx = tag[k].regRef.idx;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    idQ <= issue.id;
    for (int k = 0; k < regReadPkg::NUM_OPERANDS; k++) begin
      useConstQ[k] <= tag[k].constVal.isConst;
      constQ[k] <= tag[k].constVal.value;
    end
  end

  // ************************************************************
  // Execute micro-op
  // ************************************************************
  always_comb begin
    for (int k = 0; k < regReadPkg::NUM_OPERANDS; k++) begin
      operand[k] = useConstQ[k] ? {{PAD_W{1'b0}}, constQ[k]} : readData[k];
    end
    exUop.valid = validQ;
    exUop.id = idQ;
    exUop.opA = operand[0];
    exUop.opB = operand[1];
  end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic clk,
  input  logic rstN,
  input  regReadPkg::wbUopT [regReadPkg::NUM_WB-1:0] wb,
  input  logic [regReadPkg::NUM_PHY_READS-1:0][regReadPkg::REG_IDX_W-1:0] rdIdx,
  input  logic [regReadPkg::NUM_PHY_READS-1:0] rdEn,
  output logic [regReadPkg::NUM_PHY_READS-1:0][regReadPkg::DATA_W-1:0] rdData
);

  logic [regReadPkg::DATA_W-1:0] regs [regReadPkg::NUM_REGS];
  logic [regReadPkg::NUM_WB-1:0] wrEn;
  logic [regReadPkg::NUM_PHY_READS-1:0][regReadPkg::DATA_W-1:0] rdNext;

  always_comb begin
    for (int w = 0; w < regReadPkg::NUM_WB; w++) begin
      wrEn[w] = wb[w].valid && !wb[w].dst.regRef.noReg; // Constant tags write nothing.
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int r = 0; r < regReadPkg::NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int w = 0; w < regReadPkg::NUM_WB; w++) begin
        if (wrEn[w]) begin
          regs[wb[w].dst.regRef.idx] <= wb[w].result; // Higher bus wins.
        end
      end
    end
  end

  // Write-first bypass of this edge's writebacks.
  always_comb begin
    for (int p = 0; p < regReadPkg::NUM_PHY_READS; p++) begin
      rdNext[p] = regs[rdIdx[p]];
      for (int w = 0; w < regReadPkg::NUM_WB; w++) begin
        if (wrEn[w] && wb[w].dst.regRef.idx == rdIdx[p]) begin
          rdNext[p] = wb[w].result;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < regReadPkg::NUM_PHY_READS; p++) begin
      if (rdEn[p]) begin
        rdData[p] <= rdNext[p];
      end
    end
  end

endmodule

/* rtl/regReadPkg.sv */
package regReadPkg;

  // ************************************************************
  // Sizes
  // ************************************************************
  localparam int DATA_W = 32;
  localparam int REG_IDX_W = 6;
  localparam int NUM_REGS = 64;
  localparam int ID_W = 4;
  localparam int NUM_WB = 2;
  localparam int NUM_OPERANDS = 2; // Logical reads 0 and 1, store data follows.
  localparam int NUM_LOG_READS = 3;
  localparam int NUM_PHY_READS = 2;
  localparam int PORT_IDX_W = 1; // Selects one physical read port.

  // ************************************************************
  // Tags
  // ************************************************************
  typedef struct packed {
    logic noReg; // Clear for a physical register.
    logic [REG_IDX_W-1:0] idx;
  } regRefT;

  typedef struct packed {
    logic isConst;
    logic [REG_IDX_W-1:0] value; // Zero-extended on use.
  } constTagT;

  typedef union packed {
    regRefT regRef;
    constTagT constVal;
  } regTagT;

  // ************************************************************
  // Micro-ops and requests
  // ************************************************************
  typedef struct packed {
    logic valid;
    regTagT dst;
    logic [DATA_W-1:0] result;
  } wbUopT;

  typedef struct packed {
    logic valid;
    logic [ID_W-1:0] id;
    regTagT tagA;
    regTagT tagB;
  } issueUopT;

  typedef struct packed {
    logic valid;
    logic [ID_W-1:0] id;
    logic [DATA_W-1:0] opA;
    logic [DATA_W-1:0] opB;
  } exUopT;

  typedef struct packed {
    logic valid;
    logic [ID_W-1:0] id;
    regTagT tag;
  } stDataReqT;

  typedef struct packed {
    logic valid;
    logic [ID_W-1:0] id;
    logic [DATA_W-1:0] data;
  } stDataUopT;

  typedef struct packed {
    logic valid;
    logic [REG_IDX_W-1:0] idx;
  } rfReadReqT;

endpackage

/* rtl/regReadStage.sv */
`timescale 1ns/1ps

module regReadStage (
  input  logic clk,
  input  logic rstN,
  input  regReadPkg::wbUopT [regReadPkg::NUM_WB-1:0] wb,
  input  regReadPkg::issueUopT issue,
  input  regReadPkg::stDataReqT stDataReq,
  output logic stDataReady,
  output regReadPkg::exUopT exUop,
  output regReadPkg::stDataUopT stDataUop
);

  // ************************************************************
  // Logical and physical read wiring
  // ************************************************************
  wire regReadPkg::rfReadReqT [regReadPkg::NUM_LOG_READS-1:0] logReq;
  wire [regReadPkg::NUM_LOG_READS-1:0] logGrant;
  wire [regReadPkg::NUM_LOG_READS-1:0][regReadPkg::DATA_W-1:0] logData;
  wire [regReadPkg::NUM_PHY_READS-1:0][regReadPkg::REG_IDX_W-1:0] rdIdx;
  wire [regReadPkg::NUM_PHY_READS-1:0] rdEn;
  wire [regReadPkg::NUM_PHY_READS-1:0][regReadPkg::DATA_W-1:0] rdData;

  operandFetch opFetch (
    .clk(clk),
    .rstN(rstN),
    .issue(issue),
    .readReq(logReq[regReadPkg::NUM_OPERANDS-1:0]),
    .readData(logData[regReadPkg::NUM_OPERANDS-1:0]),
    .exUop(exUop)
  );

  storeDataFetch stFetch (
    .clk(clk),
    .rstN(rstN),
    .stDataReq(stDataReq),
    .grant(logGrant[regReadPkg::NUM_OPERANDS]), // Store data follows the operands.
    .stDataReady(stDataReady),
    .readReq(logReq[regReadPkg::NUM_OPERANDS]),
    .readData(logData[regReadPkg::NUM_OPERANDS]),
    .stDataUop(stDataUop)
  );

  rfReadArbiter rdArb (
    .clk(clk),
    .rstN(rstN),
    .logReq(logReq),
    .logGrant(logGrant),
    .logData(logData),
    .rdIdx(rdIdx),
    .rdEn(rdEn),
    .rdData(rdData)
  );

  regFile rf (
    .clk(clk),
    .rstN(rstN),
    .wb(wb),
    .rdIdx(rdIdx),
    .rdEn(rdEn),
    .rdData(rdData)
  );

endmodule

/* rtl/rfReadArbiter.sv */
`timescale 1ns/1ps

module rfReadArbiter (
  input  logic clk,
  input  logic rstN,
  input  regReadPkg::rfReadReqT [regReadPkg::NUM_LOG_READS-1:0] logReq,
  output logic [regReadPkg::NUM_LOG_READS-1:0] logGrant,
  output logic [regReadPkg::NUM_LOG_READS-1:0][regReadPkg::DATA_W-1:0] logData,
  output logic [regReadPkg::NUM_PHY_READS-1:0][regReadPkg::REG_IDX_W-1:0] rdIdx,
  output logic [regReadPkg::NUM_PHY_READS-1:0] rdEn,
  input  logic [regReadPkg::NUM_PHY_READS-1:0][regReadPkg::DATA_W-1:0] rdData
);

  // ************************************************************
  // Request cycle
  // ************************************************************
  logic [regReadPkg::PORT_IDX_W:0] portsUsed;
  logic [regReadPkg::PORT_IDX_W-1:0] nextPort;
  logic [regReadPkg::NUM_LOG_READS-1:0][regReadPkg::PORT_IDX_W-1:0] portSel;
  logic [regReadPkg::NUM_LOG_READS-1:0][regReadPkg::PORT_IDX_W-1:0] portSelQ;

  // Fixed priority, lowest logical index takes the next free port.
  always_comb begin
    portsUsed = '0;
    nextPort = '0;
    logGrant = '0;
    portSel = '0;
    rdIdx = '0;
    rdEn = '0;
    for (int i = 0; i < regReadPkg::NUM_LOG_READS; i++) begin
      nextPort = portsUsed[regReadPkg::PORT_IDX_W-1:0];
      if (logReq[i].valid && portsUsed < regReadPkg::NUM_PHY_READS) begin
        logGrant[i] = 1'b1;
        portSel[i] = nextPort;
        rdIdx[nextPort] = logReq[i].idx;
        rdEn[nextPort] = 1'b1;
        portsUsed = portsUsed + 1'b1;
      end
    end
  end

  // ************************************************************
  // Data cycle
  // ************************************************************
  always_ff @(posedge clk) begin
    if (!rstN) begin
      portSelQ <= '0;
    end else begin
      portSelQ <= portSel;
    end
  end

  always_comb begin
    for (int i = 0; i < regReadPkg::NUM_LOG_READS; i++) begin
      logData[i] = rdData[portSelQ[i]]; // Steer the serving port back.
    end
  end

endmodule

/* rtl/storeDataFetch.sv */
`timescale 1ns/1ps

module storeDataFetch (
  input  logic clk,
  input  logic rstN,
  input  regReadPkg::stDataReqT stDataReq,
  input  logic grant,
  output logic stDataReady,
  output regReadPkg::rfReadReqT readReq,
  input  logic [regReadPkg::DATA_W-1:0] readData,
  output regReadPkg::stDataUopT stDataUop
);

  localparam int PAD_W = regReadPkg::DATA_W - regReadPkg::REG_IDX_W;

  logic isReg;
  logic xfer;
  logic validQ;
  logic useConstQ;
  logic [regReadPkg::ID_W-1:0] idQ;
  logic [regReadPkg::REG_IDX_W-1:0] constQ;

  assign isReg = !stDataReq.tag.regRef.noReg;
  assign readReq.valid = stDataReq.valid && isReg;
  assign readReq.idx = stDataReq.tag.regRef.idx;
  assign stDataReady = isReg ? grant : 1'b1; // Constants need no port.
  assign xfer = stDataReq.valid && stDataReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= xfer;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      idQ <= stDataReq.id;
      useConstQ <= stDataReq.tag.constVal.isConst;
      constQ <= stDataReq.tag.constVal.value;
    end
  end

  always_comb begin
    stDataUop.valid = validQ;
    stDataUop.id = idQ;
    stDataUop.data = useConstQ ? {{PAD_W{1'b0}}, constQ} : readData;
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the register read stage testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f tb.f --top-module regReadStageTb \
  --Mdir "$BUILD_DIR" -o simRegRead
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/simRegRead" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

/* tb.f */
rtl/regReadPkg.sv
rtl/regFile.sv
rtl/rfReadArbiter.sv
rtl/operandFetch.sv
rtl/storeDataFetch.sv
rtl/regReadStage.sv
tb/regReadStage_assertions.sv
tb/regReadStageTb.sv

/* tb/regReadStageTb.sv */
`timescale 1ns/1ps

module regReadStageTb;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 10;
  localparam int DIRECTED_CYCLES = 130;
  localparam int RANDOM_CYCLES = 400;
  localparam int TEST_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
  localparam int PAD_W = regReadPkg::DATA_W - regReadPkg::REG_IDX_W;
  localparam regReadPkg::wbUopT NO_WB = '0;

  logic clk;
  logic rstN;
  regReadPkg::wbUopT [regReadPkg::NUM_WB-1:0] wb;
  regReadPkg::issueUopT issue;
  regReadPkg::stDataReqT stDataReq;
  logic stDataReady;
  regReadPkg::exUopT exUop;
  regReadPkg::stDataUopT stDataUop;

  logic [regReadPkg::DATA_W-1:0] regModel [regReadPkg::NUM_REGS]; // Reference registers.
  regReadPkg::exUopT exQ [$];
  regReadPkg::stDataUopT stQ [$];
  integer seed;
  logic stXfer;

  regReadStage dut0 (
    .clk(clk),
    .rstN(rstN),
    .wb(wb),
    .issue(issue),
    .stDataReq(stDataReq),
    .stDataReady(stDataReady),
    .exUop(exUop),
    .stDataUop(stDataUop)
  );

  bind regReadStage regReadStageAssertions assertions0 (
    .clk(clk),
    .rstN(rstN),
    .issue(issue),
    .stDataReq(stDataReq),
    .stDataReady(stDataReady),
    .exUop(exUop),
    .stDataUop(stDataUop)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ************************************************************
  // Reference model and helpers
  // ************************************************************
  function automatic logic [regReadPkg::DATA_W-1:0] expectOperand(input regReadPkg::regTagT tag);
    if (tag.regRef.noReg) begin
      return {{PAD_W{1'b0}}, tag.constVal.value}; // Zero-extended constant.
    end
    return regModel[tag.regRef.idx];
  endfunction

  function automatic regReadPkg::regTagT regTag(input int idx);
    return {1'b0, idx[regReadPkg::REG_IDX_W-1:0]};
  endfunction

  function automatic regReadPkg::regTagT constTag(input int value);
    return {1'b1, value[regReadPkg::REG_IDX_W-1:0]};
  endfunction

  function automatic regReadPkg::issueUopT issueOp(input int id, input regReadPkg::regTagT tagA,
      input regReadPkg::regTagT tagB);
    return {1'b1, id[regReadPkg::ID_W-1:0], tagA, tagB};
  endfunction

  function automatic regReadPkg::stDataReqT storeReq(input int id, input regReadPkg::regTagT tag);
    return {1'b1, id[regReadPkg::ID_W-1:0], tag};
  endfunction

  function automatic regReadPkg::wbUopT writeback(input regReadPkg::regTagT tag,
      input logic [regReadPkg::DATA_W-1:0] data);
    return {1'b1, tag, data};
  endfunction

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Run stopped.");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
      input logic [63:0] expected);
    if (got !== expected) begin
      stopWithFailure($sformatf("ERROR: %s got 0x%0h expected 0x%0h", name, got, expected));
    end
  endtask

  // Records what the DUT takes at this edge.
  task automatic recordEdge();
    regReadPkg::exUopT exExp;
    regReadPkg::stDataUopT stExp;
    for (int w = 0; w < regReadPkg::NUM_WB; w++) begin
      if (wb[w].valid && !wb[w].dst.regRef.noReg) begin
        regModel[wb[w].dst.regRef.idx] = wb[w].result; // Bus 1 applied last.
      end
    end
    if (issue.valid) begin
      exExp.valid = 1'b1;
      exExp.id = issue.id;
      exExp.opA = expectOperand(issue.tagA);
      exExp.opB = expectOperand(issue.tagB);
      exQ.push_back(exExp);
    end
    stXfer = stDataReq.valid && stDataReady;
    if (stXfer) begin
      stExp.valid = 1'b1;
      stExp.id = stDataReq.id;
      stExp.data = expectOperand(stDataReq.tag);
      stQ.push_back(stExp);
    end
  endtask

  task automatic runCycle(input regReadPkg::wbUopT [regReadPkg::NUM_WB-1:0] nextWb,
      input regReadPkg::issueUopT nextIssue, input regReadPkg::stDataReqT nextSt);
    @(posedge clk);
    recordEdge();
    wb <= nextWb;
    issue <= nextIssue;
    if (stXfer || !stDataReq.valid) begin
      stDataReq <= nextSt; // A pending request is held.
    end
  endtask

  task automatic randomCycle();
    regReadPkg::wbUopT [regReadPkg::NUM_WB-1:0] rWb;
    regReadPkg::issueUopT rIssue;
    regReadPkg::stDataReqT rSt;
    logic [31:0] r;
    for (int w = 0; w < regReadPkg::NUM_WB; w++) begin
      r = $random(seed);
      rWb[w].valid = r[0];
      rWb[w].dst = {r[1] & r[2], r[8:3]}; // Constant form one time in four.
      r = $random(seed);
      rWb[w].result = r;
    end
    r = $random(seed);
    rIssue = {r[0] | r[1], r[5:2], r[6] & r[7], r[13:8], r[14] & r[15], r[21:16]};
    r = $random(seed);
    rSt = {r[0], r[4:1], r[5] & r[6], r[12:7]};
    runCycle(rWb, rIssue, rSt);
  endtask

  // ************************************************************
  // Stimulus
  // ************************************************************
  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    wb = '0;
    issue = '0;
    stDataReq = '0;
    seed = 54;
    for (int r = 0; r < regReadPkg::NUM_REGS; r++) begin
      regModel[r] = '0;
    end
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk);
      wb <= {writeback(regTag(2 * c + 1), ~32'h0),
        writeback(regTag(2 * c), 32'h1)}; // Dropped under reset.
    end
    rstN <= 1'b1;
    wb <= '0;
    repeat (2) runCycle('0, '0, '0);
    for (int r = 0; r < regReadPkg::NUM_REGS; r += 2) begin
      runCycle('0, issueOp(r / 2, regTag(r), regTag(r + 1)), '0); // Zero after reset.
    end
    for (int r = 0; r < regReadPkg::NUM_REGS; r += 2) begin
      runCycle({writeback(regTag(r + 1), ~$random(seed)),
        writeback(regTag(r), $random(seed))}, '0, '0);
    end
    for (int k = 0; k < 32; k++) begin
      runCycle('0, issueOp(k, regTag(2 * k + 1), regTag(63 - k)), '0);
    end
    for (int k = 0; k < 8; k++) begin
      runCycle('0, issueOp(k, constTag(k * 9), regTag(k)), '0);
    end
    runCycle({NO_WB, writeback(constTag(5), 32'hDEAD_BEEF)},
      issueOp(9, regTag(5), constTag(63)), '0);
    runCycle('0, issueOp(10, regTag(5), regTag(5)), '0);
    // Store arbitration against two-register issues.
    runCycle('0, issueOp(1, regTag(10), regTag(11)), storeReq(2, regTag(12)));
    runCycle('0, issueOp(3, regTag(13), regTag(14)), '0);
    runCycle('0, issueOp(4, constTag(9), regTag(15)), '0);
    runCycle('0, issueOp(5, regTag(16), regTag(17)), storeReq(6, constTag(33)));
    runCycle('0, '0, storeReq(7, regTag(20)));
    runCycle('0, '0, '0);
    // Write-first with both buses on one register.
    runCycle({writeback(regTag(7), 32'h5A5A_0002), writeback(regTag(7), 32'hA5A5_0001)},
      issueOp(11, regTag(7), constTag(1)), storeReq(12, regTag(7)));
    runCycle('0, issueOp(13, regTag(7), regTag(8)), '0);
    runCycle('0, '0, '0);
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      randomCycle();
    end
    repeat (3) runCycle('0, '0, '0);
    @(negedge clk);
    if (exQ.size() != 0 || stQ.size() != 0) begin
      stopWithFailure("Expected outputs were still outstanding at the end of the run");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

  // ************************************************************
  // Compare process
  // ************************************************************
  always @(negedge clk) begin : compareOutputs
    regReadPkg::exUopT exExp;
    regReadPkg::stDataUopT stExp;
    logic readyExp;
    if (rstN) begin
      if (exUop.valid === 1'b1) begin
        if (exQ.size() == 0) begin
          stopWithFailure("exUop was valid with no issue outstanding");
        end else begin
          exExp = exQ.pop_front();
          checkValue("exUop.id", 64'(exUop.id), 64'(exExp.id));
          checkValue("exUop.opA", 64'(exUop.opA), 64'(exExp.opA));
          checkValue("exUop.opB", 64'(exUop.opB), 64'(exExp.opB));
        end
      end else if (exQ.size() != 0) begin
        stopWithFailure("exUop did not appear for an accepted issue");
      end
      if (stDataUop.valid === 1'b1) begin
        if (stQ.size() == 0) begin
          stopWithFailure("stDataUop was valid with no store transfer outstanding");
        end else begin
          stExp = stQ.pop_front();
          checkValue("stDataUop.id", 64'(stDataUop.id), 64'(stExp.id));
          checkValue("stDataUop.data", 64'(stDataUop.data), 64'(stExp.data));
        end
      end else if (stQ.size() != 0) begin
        stopWithFailure("stDataUop did not appear for a transferred store");
      end
      if (stDataReq.valid === 1'b1) begin
        readyExp = stDataReq.tag.regRef.noReg ||
          !(issue.valid && !issue.tagA.regRef.noReg && !issue.tagB.regRef.noReg);
        checkValue("stDataReady", 64'(stDataReady), 64'(readyExp));
      end
    end
  end

  initial begin : watchdog
    #(TEST_CYCLES * CLK_PERIOD * 2);
    stopWithFailure("Timeout, the run did not reach its end in time");
  end

endmodule

/* tb/regReadStage_assertions.sv */
`timescale 1ns/1ps

module regReadStageAssertions (
  input logic clk,
  input logic rstN,
  input regReadPkg::issueUopT issue,
  input regReadPkg::stDataReqT stDataReq,
  input logic stDataReady,
  input regReadPkg::exUopT exUop,
  input regReadPkg::stDataUopT stDataUop
);

  logic twoRegIssue;
  logic storeXfer;

  assign twoRegIssue = issue.valid && !issue.tagA.regRef.noReg && !issue.tagB.regRef.noReg;
  assign storeXfer = stDataReq.valid && stDataReady;

  // One cycle from issue to execute.
  exValidFollowsIssue: assert property (@(posedge clk) disable iff (!rstN)
      exUop.valid == $past(issue.valid))
    else $error("exUop.valid does not follow issue.valid");

  stValidFollowsXfer: assert property (@(posedge clk) disable iff (!rstN)
      stDataUop.valid == $past(storeXfer))
    else $error("stDataUop.valid does not follow the store transfer");

  // Both ports are taken by the operands.
  storeBlockedByIssue: assert property (@(posedge clk) disable iff (!rstN)
      (twoRegIssue && !stDataReq.tag.regRef.noReg) |-> !stDataReady)
    else $error("stDataReady high while both read ports are taken");

endmodule
